/* Makefile */
# Verilator build and run for the segmented memory testbench

VERILATOR  ?= verilator
TOP        := seg_mem_tb
RTL_TOP    := seg_mem_top
FILELIST   := tb.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing
LOG        := sim.log
PASS_MSG   := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation result: PASS"; \
	else \
		echo "simulation result: FAIL"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		rtl/seg_mem_pkg.sv rtl/seg_mem_array.sv rtl/seg_read_tracker.sv \
		rtl/seg_read_hold.sv rtl/seg_mem_top.sv
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* rtl/seg_mem_array.sv */
`timescale 1ns/100ps
`default_nettype none

// single port storage, byte masked writes, registered read word
module seg_mem_array #(
  parameter int els_p = 16,
  localparam int addr_w_lp = (els_p > 1) ? $clog2(els_p) : 1
) (
  input  wire logic                              clk,
  input  wire logic                              rst_i,
  input  wire logic [seg_mem_pkg::SEG_N-1:0]     v_i,
  input  wire logic                              w_i,
  input  wire logic [addr_w_lp-1:0]              addr_i,
  input  wire seg_mem_pkg::seg_word_u            data_i,
  input  wire logic [seg_mem_pkg::MASK_W-1:0]    w_mask_i,
  output seg_mem_pkg::seg_word_u                 raw_data_o
);

  import seg_mem_pkg::*;

  localparam int bytes_per_seg_lp = SEG_W / 8;

  ////////////////////////////////////////////////////////////////////////////
  // request decode
  ////////////////////////////////////////////////////////////////////////////

  logic              req;
  logic              rd_v;
  logic [MASK_W-1:0] byte_we;

  assign req  = |v_i;
  assign rd_v = req & ~w_i;   // any segment read, same addr for all

  // each byte needs its segment strobe and its own mask bit
  for (genvar b = 0; b < MASK_W; b++) begin : g_byte_we
    assign byte_we[b] = w_i & v_i[b / bytes_per_seg_lp] & w_mask_i[b];
  end

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  seg_word_u mem [els_p];   // contents undefined until written

  always_ff @(posedge clk) begin
    for (int b = 0; b < MASK_W; b++) begin
      if (byte_we[b]) begin
        mem[addr_i].bytes[b] <= data_i.bytes[b];
      end
    end
  end

  // whole word is fetched even for a partial read,
  // the read hold picks out the segments that matter
  always_ff @(posedge clk) begin
    if (rd_v) begin
      raw_data_o <= mem[addr_i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_addr_in_range: assert property (
    @(posedge clk) disable iff (rst_i)
    req |-> (int'(addr_i) < els_p)
  ) else $error("seg_mem_array: address %0d beyond depth %0d", addr_i, els_p);

endmodule

`default_nettype wire

/* rtl/seg_mem_pkg.sv */
`default_nettype none

package seg_mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // word geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_W = 64;               // stored word width
  localparam int SEG_N  = 8;                // segments per word, one valid strobe each
  localparam int SEG_W  = DATA_W / SEG_N;   // bits per segment
  localparam int MASK_W = DATA_W / 8;       // one write mask bit per byte

  ////////////////////////////////////////////////////////////////////////////
  // two views of one data word
  ////////////////////////////////////////////////////////////////////////////

  // segment view follows v_i, byte view follows w_mask_i
  // identical layout while SEG_W is 8, a 16 bit segment would span two bytes
  typedef union packed {
    logic [SEG_N-1:0][SEG_W-1:0] segs;
    logic [MASK_W-1:0][7:0]      bytes;
  } seg_word_u;

endpackage

`default_nettype wire

/* rtl/seg_mem_top.sv */
`timescale 1ns/100ps
`default_nettype none

// segmented single port memory, one cycle read latency
module seg_mem_top #(
  parameter int els_p             = 16,
  parameter bit latch_last_read_p = 1'b1,
  localparam int addr_w_lp = (els_p > 1) ? $clog2(els_p) : 1
) (
  input  wire logic                              clk,
  input  wire logic                              rst_i,
  input  wire logic [seg_mem_pkg::SEG_N-1:0]     v_i,
  input  wire logic                              w_i,
  input  wire logic [addr_w_lp-1:0]              addr_i,
  input  wire logic [seg_mem_pkg::DATA_W-1:0]    data_i,
  input  wire logic [seg_mem_pkg::MASK_W-1:0]    w_mask_i,
  output logic      [seg_mem_pkg::DATA_W-1:0]    data_o
);

  import seg_mem_pkg::*;

  seg_word_u        raw_data;   // array word, registered on reads
  logic [SEG_N-1:0] rd_seg;     // segments read last cycle

  seg_mem_array #(
    .els_p      (els_p)
  ) u_array (
    .clk        (clk),
    .rst_i      (rst_i),
    .v_i        (v_i),
    .w_i        (w_i),
    .addr_i     (addr_i),
    .data_i     (data_i),
    .w_mask_i   (w_mask_i),
    .raw_data_o (raw_data)
  );

  // runs alongside the array, same request inputs
  seg_read_tracker u_tracker (
    .clk      (clk),
    .rst_i    (rst_i),
    .v_i      (v_i),
    .w_i      (w_i),
    .rd_seg_o (rd_seg)
  );

  seg_read_hold #(
    .latch_last_read_p (latch_last_read_p)
  ) u_hold (
    .clk        (clk),
    .rst_i      (rst_i),
    .raw_data_i (raw_data),
    .rd_seg_i   (rd_seg),
    .data_o     (data_o)
  );

endmodule

`default_nettype wire

/* rtl/seg_read_hold.sv */
`timescale 1ns/100ps
`default_nettype none

// merges the raw read word with the read flags into data_o
module seg_read_hold #(
  parameter bit latch_last_read_p = 1'b1
) (
  input  wire logic                          clk,
  input  wire logic                          rst_i,
  input  wire seg_mem_pkg::seg_word_u        raw_data_i,
  input  wire logic [seg_mem_pkg::SEG_N-1:0] rd_seg_i,
  output seg_mem_pkg::seg_word_u             data_o
);

  import seg_mem_pkg::*;

  if (latch_last_read_p) begin : g_hold

    seg_word_u hold_r;   // last value read, per segment

    always_ff @(posedge clk) begin
      if (rst_i) begin
        hold_r <= '0;
      end else begin
        for (int s = 0; s < SEG_N; s++) begin
          if (rd_seg_i[s]) begin
            hold_r.segs[s] <= raw_data_i.segs[s];
          end
        end
      end
    end

    // fresh data bypasses the hold register in its own cycle
    always_comb begin
      for (int s = 0; s < SEG_N; s++) begin
        data_o.segs[s] = rd_seg_i[s] ? raw_data_i.segs[s] : hold_r.segs[s];
      end
    end

  end else begin : g_no_hold

    // only the flagged segments carry meaning here
    assign data_o = raw_data_i;

  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // an unread segment must not move, whatever the array does meanwhile
  for (genvar s = 0; s < SEG_N; s++) begin : g_chk
    a_seg_stable: assert property (
      @(posedge clk) disable iff (rst_i)
      (latch_last_read_p && !rd_seg_i[s]) |-> (data_o.segs[s] == $past(data_o.segs[s]))
    ) else $error("seg_read_hold: segment %0d changed without a read", s);
  end

endmodule

`default_nettype wire

/* rtl/seg_read_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

// per segment flags, set in the cycle after that segment was read
module seg_read_tracker (
  input  wire logic                          clk,
  input  wire logic                          rst_i,
  input  wire logic [seg_mem_pkg::SEG_N-1:0] v_i,
  input  wire logic                          w_i,
  output logic      [seg_mem_pkg::SEG_N-1:0] rd_seg_o
);

  import seg_mem_pkg::*;

  logic [SEG_N-1:0] rd_acc;

  assign rd_acc = v_i & {SEG_N{~w_i}};   // writes never raise a flag

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rd_seg_o <= '0;
    end else begin
      rd_seg_o <= rd_acc;   // idle or write cycle clears
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // direction must be defined for the array and for the flags alike
  a_dir_known: assert property (
    @(posedge clk) disable iff (rst_i)
    (|v_i) |-> !$isunknown(w_i)
  ) else $error("seg_read_tracker: w_i unknown during a request");

  a_clear_after_reset: assert property (
    @(posedge clk)
    $fell(rst_i) |-> (rd_seg_o == '0)
  ) else $error("seg_read_tracker: read flag set right after reset");

endmodule

`default_nettype wire

/* sim/seg_mem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module seg_mem_tb;

  import seg_mem_pkg::*;

  localparam int ELS        = 16;
  localparam int ADDR_W     = $clog2(ELS);
  localparam int BPS        = SEG_W / 8;   // bytes per segment
  localparam int CLK_PERIOD = 10;
  localparam int RST_CYCLES = 16;
  localparam int PAIR_N     = 24;          // write then read, same address
  localparam int RAND_N     = 400;
  localparam int GAP_N      = 20;          // reads separated by idle cycles
  localparam int GAP_MAX    = 4;
  localparam int B2B_N      = ELS;
  // requests plus worst case idle cycles
  localparam int TEST_CYCLES = RST_CYCLES + 8 + ELS + 2 * PAIR_N + RAND_N
                               + GAP_N * (2 + 2 * GAP_MAX) + B2B_N;
  localparam int TIMEOUT_NS  = (TEST_CYCLES + 100) * CLK_PERIOD;

  logic              clk;
  logic              rst_i;
  logic [SEG_N-1:0]  v_i;
  logic              w_i;
  logic [ADDR_W-1:0] addr_i;
  logic [DATA_W-1:0] data_i;
  logic [MASK_W-1:0] w_mask_i;
  logic [DATA_W-1:0] data_o;

  integer seed   = 32'h319e3eef;
  int     errors = 0;

  seg_mem_top #(
    .els_p             (ELS),
    .latch_last_read_p (1'b1)
  ) u_dut (
    .clk      (clk),
    .rst_i    (rst_i),
    .v_i      (v_i),
    .w_i      (w_i),
    .addr_i   (addr_i),
    .data_i   (data_i),
    .w_mask_i (w_mask_i),
    .data_o   (data_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // shadow model
  ////////////////////////////////////////////////////////////////////////////

  logic [7:0]        model_byte  [ELS][MASK_W];
  logic              model_known [ELS][MASK_W];
  logic [DATA_W-1:0] exp_data;    // expected data_o after this edge
  logic [SEG_N-1:0]  exp_known;   // segment fully defined in the model
  logic [SEG_N-1:0]  exp_rd;      // segments read at the previous edge
  logic              read_seen;

  // sees the inputs the DUT samples at the same edge
  always @(posedge clk) begin : shadow_model
    logic seg_ok;
    if (rst_i) begin
      exp_data  <= '0;   // hold registers clear on reset
      exp_known <= '1;
      exp_rd    <= '0;
      read_seen <= 1'b0;
      for (int a = 0; a < ELS; a++) begin
        for (int b = 0; b < MASK_W; b++) begin
          model_known[a][b] = 1'b0;
        end
      end
    end else if (|v_i && !w_i) begin
      read_seen <= 1'b1;
      exp_rd    <= v_i;
      for (int s = 0; s < SEG_N; s++) begin
        if (v_i[s]) begin
          seg_ok = 1'b1;
          for (int k = 0; k < BPS; k++) begin
            exp_data[(s*BPS+k)*8 +: 8] <= model_byte[addr_i][s*BPS+k];
            seg_ok = seg_ok & model_known[addr_i][s*BPS+k];
          end
          exp_known[s] <= seg_ok;
        end
      end
    end else begin
      exp_rd <= '0;   // idle or write, unread segments hold
      if (|v_i && w_i) begin
        for (int b = 0; b < MASK_W; b++) begin
          if (v_i[b / BPS] && w_mask_i[b]) begin
            model_byte[addr_i][b]  = data_i[b*8 +: 8];
            model_known[addr_i][b] = 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_zero_until_read: assert property (
    @(posedge clk) disable iff (rst_i)
    !read_seen |-> (data_o == '0)
  ) else begin
    errors++;
    $display("** Error at %0t: data_o is %h before any read", $time, $sampled(data_o));
  end

  a_no_x_out: assert property (
    @(posedge clk) disable iff (rst_i)
    !$isunknown(data_o)
  ) else begin
    errors++;
    $display("** Error at %0t: data_o has unknown bits %h", $time, $sampled(data_o));
  end

  for (genvar s = 0; s < SEG_N; s++) begin : g_seg_chk
    a_read_seg: assert property (
      @(posedge clk) disable iff (rst_i)
      (exp_rd[s] && exp_known[s]) |->
        (data_o[s*SEG_W +: SEG_W] == exp_data[s*SEG_W +: SEG_W])
    ) else begin
      errors++;
      $display("** Error at %0t: read segment %0d got %h expected %h", $time, s,
               $sampled(data_o[s*SEG_W +: SEG_W]), $sampled(exp_data[s*SEG_W +: SEG_W]));
    end

    a_hold_seg: assert property (
      @(posedge clk) disable iff (rst_i)
      (!exp_rd[s] && exp_known[s]) |->
        (data_o[s*SEG_W +: SEG_W] == exp_data[s*SEG_W +: SEG_W])
    ) else begin
      errors++;
      $display("** Error at %0t: held segment %0d got %h expected %h", $time, s,
               $sampled(data_o[s*SEG_W +: SEG_W]), $sampled(exp_data[s*SEG_W +: SEG_W]));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  function automatic logic [DATA_W-1:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi, lo};
  endfunction

  task automatic issue_request(input logic [SEG_N-1:0] v, input logic w,
                               input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                               input logic [MASK_W-1:0] m);
    @(posedge clk);
    v_i      <= v;
    w_i      <= w;
    addr_i   <= a;
    data_i   <= d;
    w_mask_i <= m;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      v_i <= '0;
      w_i <= 1'b0;
    end
  endtask

  initial begin : stimulus
    logic [31:0]       r;
    logic [ADDR_W-1:0] a;
    rst_i    <= 1'b1;
    v_i      <= '0;
    w_i      <= 1'b0;
    addr_i   <= '0;
    data_i   <= '0;
    w_mask_i <= '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_i <= 1'b0;
    idle_cycles(4);   // output must stay zero here

    for (int i = 0; i < ELS; i++) begin   // fill, every byte known
      issue_request('1, 1'b1, ADDR_W'(i), rand_word(), '1);
    end

    for (int i = 0; i < PAIR_N; i++) begin   // partial write, full read back
      r = next_rand();
      a = r[ADDR_W-1:0];
      issue_request(r[15:8], 1'b1, a, rand_word(), r[23:16]);
      issue_request('1, 1'b0, a, '0, '0);
    end

    for (int i = 0; i < RAND_N; i++) begin
      r = next_rand();
      issue_request(r[7:0], r[8], r[12 +: ADDR_W], rand_word(), r[23:16]);
    end

    // holds must survive idles and writes
    for (int i = 0; i < GAP_N; i++) begin
      r = next_rand();
      issue_request(r[7:0] | 8'h01, 1'b0, r[8 +: ADDR_W], '0, '0);
      idle_cycles(1 + int'(r[17:16]));
      issue_request(r[31:24], 1'b1, r[20 +: ADDR_W], rand_word(), '1);
      idle_cycles(1 + int'(r[19:18]));
    end

    for (int i = 0; i < B2B_N; i++) begin   // one read per cycle, new address each
      issue_request('1, 1'b0, ADDR_W'(i), '0, '0);
    end
    idle_cycles(4);

    $display("closing report: %0d error(s)", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("watchdog: simulation timed out after %0d ns", TIMEOUT_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
rtl/seg_mem_pkg.sv
rtl/seg_mem_array.sv
rtl/seg_read_tracker.sv
rtl/seg_read_hold.sv
rtl/seg_mem_top.sv
sim/seg_mem_tb.sv
